//--- list.f
logic/dma_pkg.sv
logic/dma_regs.sv
logic/bundle_ram.sv
logic/weight_desc_gen.sv
logic/pixel_desc_gen.sv
logic/out_desc_ctrl.sv
logic/dma_ctrl_top.sv
test/dma_tb.sv

//--- logic/bundle_ram.sv
`timescale 1ns/1ps
`default_nettype none

module bundle_ram #(
  parameter  int N_BUNDLES_MAX = 8,
  localparam int IDX_W         = $clog2(N_BUNDLES_MAX)
) (
  input  wire                         clk,
  input  wire                         rstn,
  input  wire                         i_wr_en,
  input  wire  [dma_pkg::ADDR_W-1:0]  i_wr_addr,
  input  wire  [dma_pkg::DATA_W-1:0]  i_wr_data,
  input  wire                         i_w_rd_req,
  input  wire  [IDX_W-1:0]            i_w_rd_idx,
  input  wire                         i_x_rd_req,
  input  wire  [IDX_W-1:0]            i_x_rd_idx,
  output dma_pkg::bundle_t            o_row,
  output logic                        o_w_row_valid,
  output logic                        o_x_row_valid
);

  localparam int ROW_W  = $bits(dma_pkg::bundle_t);
  localparam int WORDS  = ROW_W / dma_pkg::DATA_W;  // 8 words per row
  localparam int WORD_W = $clog2(WORDS);

  logic [ROW_W-1:0]           mem [N_BUNDLES_MAX];
  logic [dma_pkg::ADDR_W-1:0] wr_word;  // word offset inside the table
  logic [IDX_W-1:0]           wr_row;
  logic [WORD_W-1:0]          wr_col;
  logic                       wr_hit;
  logic [IDX_W-1:0]           rd_idx;

  assign wr_word = i_wr_addr - dma_pkg::REG_SPAN;
  assign wr_row  = wr_word[WORD_W +: IDX_W];
  assign wr_col  = wr_word[WORD_W-1:0];
  assign wr_hit  = i_wr_en && i_wr_addr >= dma_pkg::REG_SPAN
                   && wr_word < N_BUNDLES_MAX * WORDS;
  assign rd_idx  = i_x_rd_req ? i_x_rd_idx : i_w_rd_idx;  // pixels side wins

  always_ff @(posedge clk) begin
    if (wr_hit)
      mem[wr_row][wr_col*dma_pkg::DATA_W +: dma_pkg::DATA_W] <= i_wr_data;
    if (i_x_rd_req || i_w_rd_req)
      o_row <= mem[rd_idx];
  end

  // valid goes only to the generator that was granted
  always_ff @(posedge clk) begin
    if (!rstn) begin
      o_x_row_valid <= 1'b0;
      o_w_row_valid <= 1'b0;
    end else begin
      o_x_row_valid <= i_x_rd_req;
      o_w_row_valid <= i_w_rd_req && !i_x_rd_req;
    end
  end

endmodule

`default_nettype wire

//--- logic/dma_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module dma_ctrl_top #(
  parameter int N_BUNDLES_MAX = 8
) (
  input  wire                         clk,
  input  wire                         rstn,
  input  wire                         i_wr_en,
  input  wire  [dma_pkg::ADDR_W-1:0]  i_wr_addr,
  input  wire  [dma_pkg::DATA_W-1:0]  i_wr_data,
  input  wire                         i_rd_en,
  input  wire  [dma_pkg::ADDR_W-1:0]  i_rd_addr,
  output logic [dma_pkg::DATA_W-1:0]  o_rd_data,
  input  wire                         i_o_valid,
  input  wire                         i_o_ready,
  input  wire                         i_o_last,
  input  wire  [dma_pkg::LEN_W-1:0]   i_o_bpt,
  input  wire                         i_os_valid,
  input  wire  [dma_pkg::TAG_W-1:0]   i_os_tag,
  input  wire  [3:0]                  i_os_error,
  output dma_pkg::desc_t              o_wd,
  output logic                        o_wd_valid,
  input  wire                         i_wd_ready,
  output dma_pkg::desc_t              o_xd,
  output logic                        o_xd_valid,
  input  wire                         i_xd_ready,
  output logic [dma_pkg::ADDR_W-1:0]  o_od_addr,
  output logic [dma_pkg::LEN_W-1:0]   o_od_len,
  output logic [dma_pkg::TAG_W-1:0]   o_od_tag,
  output logic                        o_od_valid,
  input  wire                         i_od_ready
);

  localparam int IDX_W = $clog2(N_BUNDLES_MAX);

  logic                             start, bundle_go, go_taken;
  logic [dma_pkg::DATA_W-1:0]       n_bundles;
  logic [dma_pkg::ADDR_W-1:0]       weights_base;
  logic [1:0][dma_pkg::ADDR_W-1:0]  ocm_base;
  logic [1:0]                       done_read;
  logic                             w_idle, x_idle;
  logic                             bank_claim, claim_idx, write_done, done_idx;
  logic                             o_done_set, o_done_clr;
  logic                             w_rd_req, x_rd_req, w_row_valid, x_row_valid;
  logic [IDX_W-1:0]                 w_rd_idx, x_rd_idx;
  dma_pkg::bundle_t                 row;

  dma_regs regs_i (
    .clk(clk), .rstn(rstn),
    .i_wr_en(i_wr_en), .i_wr_addr(i_wr_addr), .i_wr_data(i_wr_data),
    .i_rd_en(i_rd_en), .i_rd_addr(i_rd_addr), .o_rd_data(o_rd_data),
    .i_w_idle(w_idle), .i_x_idle(x_idle), .i_go_taken(go_taken),
    .i_bank_claim(bank_claim), .i_claim_idx(claim_idx),
    .i_write_done(write_done), .i_done_idx(done_idx),
    .i_o_done_set(o_done_set), .i_o_done_clr(o_done_clr),
    .o_start(start), .o_n_bundles(n_bundles), .o_weights_base(weights_base),
    .o_ocm_base(ocm_base), .o_done_read(done_read), .o_bundle_go(bundle_go)
  );

  bundle_ram #(.N_BUNDLES_MAX(N_BUNDLES_MAX)) ram_i (
    .clk(clk), .rstn(rstn),
    .i_wr_en(i_wr_en), .i_wr_addr(i_wr_addr), .i_wr_data(i_wr_data),
    .i_w_rd_req(w_rd_req), .i_w_rd_idx(w_rd_idx),
    .i_x_rd_req(x_rd_req), .i_x_rd_idx(x_rd_idx),
    .o_row(row), .o_w_row_valid(w_row_valid), .o_x_row_valid(x_row_valid)
  );

  weight_desc_gen #(.N_BUNDLES_MAX(N_BUNDLES_MAX)) wgen_i (
    .clk(clk), .rstn(rstn), .i_start(start),
    .i_n_bundles(n_bundles), .i_weights_base(weights_base),
    .o_rd_req(w_rd_req), .o_rd_idx(w_rd_idx),
    .i_row(row), .i_row_valid(w_row_valid),
    .o_desc(o_wd), .o_valid(o_wd_valid), .i_ready(i_wd_ready), .o_idle(w_idle)
  );

  pixel_desc_gen #(.N_BUNDLES_MAX(N_BUNDLES_MAX)) xgen_i (
    .clk(clk), .rstn(rstn), .i_start(start), .i_n_bundles(n_bundles),
    .i_bundle_go(bundle_go), .o_go_taken(go_taken),
    .o_rd_req(x_rd_req), .o_rd_idx(x_rd_idx),
    .i_row(row), .i_row_valid(x_row_valid),
    .o_desc(o_xd), .o_valid(o_xd_valid), .i_ready(i_xd_ready), .o_idle(x_idle)
  );

  out_desc_ctrl octrl_i (
    .clk(clk), .rstn(rstn), .i_start(start),
    .i_o_valid(i_o_valid), .i_o_ready(i_o_ready), .i_o_last(i_o_last),
    .i_o_bpt(i_o_bpt), .i_os_valid(i_os_valid), .i_os_tag(i_os_tag),
    .i_os_error(i_os_error), .i_done_read(done_read), .i_ocm_base(ocm_base),
    .o_od_addr(o_od_addr), .o_od_len(o_od_len), .o_od_tag(o_od_tag),
    .o_od_valid(o_od_valid), .i_od_ready(i_od_ready),
    .o_bank_claim(bank_claim), .o_claim_idx(claim_idx),
    .o_write_done(write_done), .o_done_idx(done_idx),
    .o_o_done_set(o_done_set), .o_o_done_clr(o_done_clr)
  );

endmodule

`default_nettype wire

//--- logic/dma_pkg.sv
`default_nettype none

package dma_pkg;

  localparam int ADDR_W   = 32;  // one word per address
  localparam int DATA_W   = 32;
  localparam int LEN_W    = 32;
  localparam int TAG_W    = 8;
  localparam int CNT_W    = 16;  // transfer and phase loops
  localparam int REG_SPAN = 16;  // bundle table starts at this address

  typedef enum logic [3:0] {
    R_START        = 4'd0,
    R_DONE_READ0   = 4'd1,
    R_DONE_READ1   = 4'd2,
    R_DONE_WRITE0  = 4'd3,
    R_DONE_WRITE1  = 4'd4,
    R_OCM_BASE0    = 4'd5,
    R_OCM_BASE1    = 4'd6,
    R_WEIGHTS_BASE = 4'd7,
    R_BUNDLE_DONE  = 4'd8,  // go flag for the pixels generator
    R_N_BUNDLES    = 4'd9,
    R_W_DONE       = 4'd10,
    R_X_DONE       = 4'd11,
    R_O_DONE       = 4'd12
  } reg_addr_e;

  // one table row, word 0 holds the lowest bits
  typedef struct packed {
    logic [63:0]       header;
    logic [CNT_W-1:0]  max_t;
    logic [CNT_W-1:0]  max_p;
    logic [LEN_W-1:0]  w_bpt;
    logic [LEN_W-1:0]  w_bpt_p0;
    logic [LEN_W-1:0]  x_bpt;
    logic [LEN_W-1:0]  x_bpt_p0;
    logic [ADDR_W-1:0] x_base;
  } bundle_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [LEN_W-1:0]  len;
    logic [64:0]       user;  // header then first-phase bit
  } desc_t;

  typedef enum logic [1:0] {W_IDLE, W_WAIT_RAM, W_EXEC} w_state_e;
  typedef enum logic [1:0] {X_IDLE, X_WAIT_RAM, X_WAIT_GO, X_EXEC} x_state_e;

endpackage

`default_nettype wire

//--- logic/dma_regs.sv
`timescale 1ns/1ps
`default_nettype none

module dma_regs (
  input  wire                              clk,
  input  wire                              rstn,
  input  wire                              i_wr_en,
  input  wire  [dma_pkg::ADDR_W-1:0]       i_wr_addr,
  input  wire  [dma_pkg::DATA_W-1:0]       i_wr_data,
  input  wire                              i_rd_en,
  input  wire  [dma_pkg::ADDR_W-1:0]       i_rd_addr,
  output logic [dma_pkg::DATA_W-1:0]       o_rd_data,
  input  wire                              i_w_idle,
  input  wire                              i_x_idle,
  input  wire                              i_go_taken,
  input  wire                              i_bank_claim,
  input  wire                              i_claim_idx,
  input  wire                              i_write_done,
  input  wire                              i_done_idx,
  input  wire                              i_o_done_set,
  input  wire                              i_o_done_clr,
  output logic                             o_start,
  output logic [dma_pkg::DATA_W-1:0]       o_n_bundles,
  output logic [dma_pkg::ADDR_W-1:0]       o_weights_base,
  output logic [1:0][dma_pkg::ADDR_W-1:0]  o_ocm_base,
  output logic [1:0]                       o_done_read,
  output logic                             o_bundle_go
);

  logic [dma_pkg::DATA_W-1:0] cfg [13];  // indexed by reg_addr_e

  always_ff @(posedge clk) begin
    if (!rstn) begin
      for (int i = 0; i < 13; i++) begin
        cfg[i] <= '0;
      end
      cfg[dma_pkg::R_DONE_READ0]  <= 32'd1;  // both banks free to fill
      cfg[dma_pkg::R_DONE_READ1]  <= 32'd1;
      cfg[dma_pkg::R_BUNDLE_DONE] <= 32'd1;
    end else begin
      if (cfg[dma_pkg::R_START][0])
        cfg[dma_pkg::R_START] <= '0;  // start lasts one cycle
      if (i_go_taken)
        cfg[dma_pkg::R_BUNDLE_DONE] <= '0;

      // claimed bank is now being written
      if (i_bank_claim) begin
        cfg[dma_pkg::R_DONE_READ0 + i_claim_idx]  <= '0;
        cfg[dma_pkg::R_DONE_WRITE0 + i_claim_idx] <= '0;
      end
      if (i_write_done)
        cfg[dma_pkg::R_DONE_WRITE0 + i_done_idx] <= 32'd1;

      cfg[dma_pkg::R_W_DONE] <= {31'd0, i_w_idle};
      cfg[dma_pkg::R_X_DONE] <= {31'd0, i_x_idle};
      if (i_o_done_clr)
        cfg[dma_pkg::R_O_DONE] <= '0;
      else if (i_o_done_set)
        cfg[dma_pkg::R_O_DONE] <= 32'd1;

      // processor write comes last so it wins
      if (i_wr_en && i_wr_addr <= dma_pkg::R_O_DONE)
        cfg[i_wr_addr[3:0]] <= i_wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn)
      o_rd_data <= '0;
    else if (i_rd_en)
      o_rd_data <= (i_rd_addr <= dma_pkg::R_O_DONE) ? cfg[i_rd_addr[3:0]] : '0;
  end

  assign o_start        = cfg[dma_pkg::R_START][0];
  assign o_n_bundles    = cfg[dma_pkg::R_N_BUNDLES];
  assign o_weights_base = cfg[dma_pkg::R_WEIGHTS_BASE];
  assign o_ocm_base[0]  = cfg[dma_pkg::R_OCM_BASE0];
  assign o_ocm_base[1]  = cfg[dma_pkg::R_OCM_BASE1];
  assign o_done_read    = {cfg[dma_pkg::R_DONE_READ1][0], cfg[dma_pkg::R_DONE_READ0][0]};
  assign o_bundle_go    = cfg[dma_pkg::R_BUNDLE_DONE][0];

endmodule

`default_nettype wire

//--- logic/out_desc_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module out_desc_ctrl (
  input  wire                              clk,
  input  wire                              rstn,
  input  wire                              i_start,
  input  wire                              i_o_valid,
  input  wire                              i_o_ready,
  input  wire                              i_o_last,
  input  wire  [dma_pkg::LEN_W-1:0]        i_o_bpt,
  input  wire                              i_os_valid,
  input  wire  [dma_pkg::TAG_W-1:0]        i_os_tag,
  input  wire  [3:0]                       i_os_error,
  input  wire  [1:0]                       i_done_read,
  input  wire  [1:0][dma_pkg::ADDR_W-1:0]  i_ocm_base,
  output logic [dma_pkg::ADDR_W-1:0]       o_od_addr,
  output logic [dma_pkg::LEN_W-1:0]        o_od_len,
  output logic [dma_pkg::TAG_W-1:0]        o_od_tag,
  output logic                             o_od_valid,
  input  wire                              i_od_ready,
  output logic                             o_bank_claim,
  output logic                             o_claim_idx,
  output logic                             o_write_done,
  output logic                             o_done_idx,
  output logic                             o_o_done_set,
  output logic                             o_o_done_clr
);

  logic bank;       // bank currently written by the DMA
  logic next_bank;
  logic last_seen;  // engine finished its previous packet
  logic claim;
  logic good;

  assign next_bank = ~bank;
  assign claim     = i_od_ready && i_o_valid && last_seen && i_done_read[next_bank];
  assign good      = i_os_valid && i_os_error == 4'd0;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      bank       <= 1'b1;  // first claim lands on bank 0
      last_seen  <= 1'b1;
      o_od_valid <= 1'b0;
    end else begin
      if (i_o_valid && i_o_ready && i_o_last)
        last_seen <= 1'b1;
      if (o_od_valid && i_od_ready)
        o_od_valid <= 1'b0;
      if (claim) begin
        bank       <= next_bank;
        o_od_valid <= 1'b1;
        last_seen  <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (claim)
      o_od_addr <= i_ocm_base[next_bank];
  end

  assign o_od_len     = i_o_bpt;
  assign o_od_tag     = {{(dma_pkg::TAG_W-1){1'b0}}, bank};
  assign o_bank_claim = claim;
  assign o_claim_idx  = next_bank;
  assign o_write_done = good;
  assign o_done_idx   = i_os_tag[0];
  assign o_o_done_set = last_seen && good;
  assign o_o_done_clr = i_start || i_o_valid;  // engine still has data to send

endmodule

`default_nettype wire

//--- logic/pixel_desc_gen.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_desc_gen #(
  parameter  int N_BUNDLES_MAX = 8,
  localparam int IDX_W         = $clog2(N_BUNDLES_MAX)
) (
  input  wire                         clk,
  input  wire                         rstn,
  input  wire                         i_start,
  input  wire  [dma_pkg::DATA_W-1:0]  i_n_bundles,
  input  wire                         i_bundle_go,
  output logic                        o_go_taken,
  output logic                        o_rd_req,
  output logic [IDX_W-1:0]            o_rd_idx,
  input  wire  dma_pkg::bundle_t      i_row,
  input  wire                         i_row_valid,
  output dma_pkg::desc_t              o_desc,
  output logic                        o_valid,
  input  wire                         i_ready,
  output logic                        o_idle
);

  dma_pkg::x_state_e          state;
  logic [dma_pkg::CNT_W-1:0]  t_cnt, p_cnt;
  logic [dma_pkg::CNT_W-1:0]  max_t, max_p;
  logic [IDX_W-1:0]           b_cnt;
  logic [63:0]                header;
  logic [dma_pkg::LEN_W-1:0]  bpt, bpt_p0;
  logic [dma_pkg::ADDR_W-1:0] addr;
  logic                       fire, first, t_last, p_last, b_last;

  assign fire   = o_valid && i_ready;
  assign first  = p_cnt == '0;
  assign t_last = t_cnt == max_t - 1'b1;
  assign p_last = p_cnt == max_p - 1'b1;
  assign b_last = b_cnt == IDX_W'(i_n_bundles - 1);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state <= dma_pkg::X_IDLE;
      t_cnt <= '0;
      p_cnt <= '0;
      b_cnt <= '0;
    end else begin
      case (state)
        dma_pkg::X_IDLE: if (i_start) begin
          state <= dma_pkg::X_WAIT_RAM;
          b_cnt <= '0;
        end
        dma_pkg::X_WAIT_RAM: if (i_row_valid) begin
          state <= dma_pkg::X_WAIT_GO;
          t_cnt <= '0;
          p_cnt <= '0;
        end
        dma_pkg::X_WAIT_GO: if (i_bundle_go)
          state <= dma_pkg::X_EXEC;  // input data for this bundle is in place
        dma_pkg::X_EXEC: if (fire) begin
          if (!t_last) begin
            t_cnt <= t_cnt + 1'b1;
          end else begin
            t_cnt <= '0;
            if (!p_last) begin
              p_cnt <= p_cnt + 1'b1;
            end else if (b_last) begin
              state <= dma_pkg::X_IDLE;
            end else begin
              b_cnt <= b_cnt + 1'b1;
              state <= dma_pkg::X_WAIT_RAM;
            end
          end
        end
        default: state <= dma_pkg::X_IDLE;
      endcase
    end
  end

  // base reloads per bundle, steps once per group of max_t transfers
  always_ff @(posedge clk) begin
    if (state == dma_pkg::X_WAIT_RAM && i_row_valid) begin
      addr   <= i_row.x_base;
      header <= i_row.header;
      max_t  <= i_row.max_t;
      max_p  <= i_row.max_p;
      bpt    <= i_row.x_bpt;
      bpt_p0 <= i_row.x_bpt_p0;
    end else if (fire && t_last) begin
      addr <= addr + o_desc.len;
    end
  end

  assign o_go_taken  = state == dma_pkg::X_WAIT_GO && i_bundle_go;
  assign o_rd_req    = state == dma_pkg::X_WAIT_RAM;
  assign o_rd_idx    = b_cnt;
  assign o_valid     = state == dma_pkg::X_EXEC;
  assign o_idle      = state == dma_pkg::X_IDLE;
  assign o_desc.addr = addr;
  assign o_desc.len  = first ? bpt_p0 : bpt;
  assign o_desc.user = {header, first};

endmodule

`default_nettype wire

//--- logic/weight_desc_gen.sv
`timescale 1ns/1ps
`default_nettype none

module weight_desc_gen #(
  parameter  int N_BUNDLES_MAX = 8,
  localparam int IDX_W         = $clog2(N_BUNDLES_MAX)
) (
  input  wire                         clk,
  input  wire                         rstn,
  input  wire                         i_start,
  input  wire  [dma_pkg::DATA_W-1:0]  i_n_bundles,
  input  wire  [dma_pkg::ADDR_W-1:0]  i_weights_base,
  output logic                        o_rd_req,
  output logic [IDX_W-1:0]            o_rd_idx,
  input  wire  dma_pkg::bundle_t      i_row,
  input  wire                         i_row_valid,
  output dma_pkg::desc_t              o_desc,
  output logic                        o_valid,
  input  wire                         i_ready,
  output logic                        o_idle
);

  dma_pkg::w_state_e          state;
  logic [dma_pkg::CNT_W-1:0]  t_cnt, p_cnt;
  logic [dma_pkg::CNT_W-1:0]  max_t, max_p;
  logic [IDX_W-1:0]           b_cnt;
  logic [63:0]                header;
  logic [dma_pkg::LEN_W-1:0]  bpt, bpt_p0;
  logic [dma_pkg::ADDR_W-1:0] addr;
  logic                       fire, first, t_last, p_last, b_last;

  assign fire   = o_valid && i_ready;
  assign first  = p_cnt == '0;
  assign t_last = t_cnt == max_t - 1'b1;
  assign p_last = p_cnt == max_p - 1'b1;
  assign b_last = b_cnt == IDX_W'(i_n_bundles - 1);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state <= dma_pkg::W_IDLE;
      t_cnt <= '0;
      p_cnt <= '0;
      b_cnt <= '0;
    end else begin
      case (state)
        dma_pkg::W_IDLE: if (i_start) begin
          state <= dma_pkg::W_WAIT_RAM;
          b_cnt <= '0;
        end
        dma_pkg::W_WAIT_RAM: if (i_row_valid) begin
          state <= dma_pkg::W_EXEC;
          t_cnt <= '0;
          p_cnt <= '0;
        end
        dma_pkg::W_EXEC: if (fire) begin
          if (!t_last) begin
            t_cnt <= t_cnt + 1'b1;
          end else begin
            t_cnt <= '0;
            if (!p_last) begin
              p_cnt <= p_cnt + 1'b1;
            end else if (b_last) begin
              state <= dma_pkg::W_IDLE;  // all bundles sent
            end else begin
              b_cnt <= b_cnt + 1'b1;
              state <= dma_pkg::W_WAIT_RAM;
            end
          end
        end
        default: state <= dma_pkg::W_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == dma_pkg::W_IDLE && i_start)
      addr <= i_weights_base;
    else if (fire)
      addr <= addr + o_desc.len;  // step on every transfer
    if (state == dma_pkg::W_WAIT_RAM && i_row_valid) begin
      header <= i_row.header;
      max_t  <= i_row.max_t;
      max_p  <= i_row.max_p;
      bpt    <= i_row.w_bpt;
      bpt_p0 <= i_row.w_bpt_p0;
    end
  end

  assign o_rd_req    = state == dma_pkg::W_WAIT_RAM;
  assign o_rd_idx    = b_cnt;
  assign o_valid     = state == dma_pkg::W_EXEC;
  assign o_idle      = state == dma_pkg::W_IDLE;
  assign o_desc.addr = addr;
  assign o_desc.len  = first ? bpt_p0 : bpt;
  assign o_desc.user = {header, first};

endmodule

`default_nettype wire

//--- test/dma_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dma_tb;

  localparam int N_BUNDLES = 3;

  typedef struct packed {
    logic [dma_pkg::TAG_W-1:0]  tag;
    logic [dma_pkg::ADDR_W-1:0] addr;
    logic [dma_pkg::LEN_W-1:0]  len;
  } od_exp_t;

  logic                        clk = 1'b0;
  logic                        rstn;
  logic                        i_wr_en, i_rd_en;
  logic [dma_pkg::ADDR_W-1:0]  i_wr_addr, i_rd_addr;
  logic [dma_pkg::DATA_W-1:0]  i_wr_data, o_rd_data;
  logic                        i_o_valid, i_o_ready, i_o_last;
  logic [dma_pkg::LEN_W-1:0]   i_o_bpt;
  logic                        i_os_valid;
  logic [dma_pkg::TAG_W-1:0]   i_os_tag;
  logic [3:0]                  i_os_error;
  dma_pkg::desc_t              o_wd, o_xd;
  logic                        o_wd_valid, i_wd_ready, o_xd_valid, i_xd_ready;
  logic [dma_pkg::ADDR_W-1:0]  o_od_addr;
  logic [dma_pkg::LEN_W-1:0]   o_od_len;
  logic [dma_pkg::TAG_W-1:0]   o_od_tag;
  logic                        o_od_valid, i_od_ready;

  dma_pkg::bundle_t            bundles [N_BUNDLES];
  int                          x_cnt [N_BUNDLES];  // pixel descriptors per bundle
  dma_pkg::desc_t              w_exp_q [$];
  dma_pkg::desc_t              x_exp_q [$];
  od_exp_t                     od_exp_q [$];
  logic [dma_pkg::ADDR_W-1:0]  weights_base;
  logic [1:0][dma_pkg::ADDR_W-1:0] ocm_base;
  int                          err_count = 0;
  int                          check_count = 0;
  int                          x_acc = 0;
  int                          od_acc = 0;
  int                          limit_cycles = 0;
  logic                        w_stall = 1'b0, x_stall = 1'b0;
  dma_pkg::desc_t              w_hold, x_hold;

  dma_ctrl_top dut_i (
    .clk(clk), .rstn(rstn),
    .i_wr_en(i_wr_en), .i_wr_addr(i_wr_addr), .i_wr_data(i_wr_data),
    .i_rd_en(i_rd_en), .i_rd_addr(i_rd_addr), .o_rd_data(o_rd_data),
    .i_o_valid(i_o_valid), .i_o_ready(i_o_ready), .i_o_last(i_o_last),
    .i_o_bpt(i_o_bpt), .i_os_valid(i_os_valid), .i_os_tag(i_os_tag),
    .i_os_error(i_os_error),
    .o_wd(o_wd), .o_wd_valid(o_wd_valid), .i_wd_ready(i_wd_ready),
    .o_xd(o_xd), .o_xd_valid(o_xd_valid), .i_xd_ready(i_xd_ready),
    .o_od_addr(o_od_addr), .o_od_len(o_od_len), .o_od_tag(o_od_tag),
    .o_od_valid(o_od_valid), .i_od_ready(i_od_ready)
  );

  initial begin
    forever #20 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [159:0] expected,
                             input logic [159:0] actual);
    check_count++;
    if (expected !== actual) begin
      err_count++;
      $display("Fail %s expected %0h actual %0h", name, expected, actual);
    end
  endtask

  task automatic reg_write(input logic [31:0] addr, input logic [31:0] data);
    @(negedge clk);
    i_wr_en   = 1'b1;
    i_wr_addr = addr;
    i_wr_data = data;
    @(negedge clk);
    i_wr_en = 1'b0;
  endtask

  task automatic reg_read(input logic [31:0] addr, output logic [31:0] data);
    @(negedge clk);
    i_rd_en   = 1'b1;
    i_rd_addr = addr;
    @(negedge clk);
    i_rd_en = 1'b0;
    data    = o_rd_data;  // registered one cycle after the request
  endtask

  // read the register until it shows the value or the read budget runs out
  task automatic poll_reg(input string name, input logic [31:0] addr,
                          input logic [31:0] value);
    logic [31:0] rd;
    rd = ~value;
    for (int i = 0; i < 16 && rd !== value; i++)
      reg_read(addr, rd);
    check_value(name, value, rd);
  endtask

  task automatic engine_packet(input int beats);
    for (int i = 0; i < beats; i++) begin
      @(negedge clk);
      i_o_valid = 1'b1;
      i_o_ready = 1'b1;
      i_o_last  = (i == beats - 1);
    end
    @(negedge clk);
    i_o_valid = 1'b0;
    i_o_ready = 1'b0;
    i_o_last  = 1'b0;
  endtask

  task automatic send_status(input logic [7:0] tag, input logic [3:0] err);
    @(negedge clk);
    i_os_valid = 1'b1;
    i_os_tag   = tag;
    i_os_error = err;
    @(negedge clk);
    i_os_valid = 1'b0;
    i_os_error = 4'd0;
  endtask

  // expected descriptor lists from the generator loop rules
  function automatic void build_expected();
    logic [31:0]      w_addr, x_addr;
    dma_pkg::desc_t   d;
    dma_pkg::bundle_t r;
    w_addr = weights_base;
    for (int b = 0; b < N_BUNDLES; b++) begin
      r = bundles[b];
      x_addr = r.x_base;  // pixels restart at each bundle's base
      x_cnt[b] = 0;
      for (int p = 0; p < r.max_p; p++) begin
        for (int t = 0; t < r.max_t; t++) begin
          d.addr = w_addr;
          d.len  = (p == 0) ? r.w_bpt_p0 : r.w_bpt;
          d.user = {r.header, p == 0};
          w_exp_q.push_back(d);
          w_addr = w_addr + d.len;
          d.addr = x_addr;
          d.len  = (p == 0) ? r.x_bpt_p0 : r.x_bpt;
          x_exp_q.push_back(d);
          x_cnt[b]++;
        end
        x_addr = x_addr + ((p == 0) ? r.x_bpt_p0 : r.x_bpt);  // one step per group
      end
    end
  endfunction

  // random ready that is high about 60 percent of cycles
  initial begin
    i_wd_ready = 1'b0;
    i_xd_ready = 1'b0;
    forever begin
      @(negedge clk);
      i_wd_ready = ($urandom % 100) < 60;
      i_xd_ready = ($urandom % 100) < 60;
    end
  end

  always @(posedge clk) begin
    dma_pkg::desc_t exp_d;
    od_exp_t        exp_o;
    if (w_stall) begin
      check_value("weights hold", w_hold, o_wd);
      check_value("weights hold valid", 1'b1, o_wd_valid);
    end
    if (x_stall) begin
      check_value("pixels hold", x_hold, o_xd);
      check_value("pixels hold valid", 1'b1, o_xd_valid);
    end
    w_stall = rstn && o_wd_valid && !i_wd_ready;
    x_stall = rstn && o_xd_valid && !i_xd_ready;
    w_hold  = o_wd;
    x_hold  = o_xd;
    if (rstn && o_wd_valid && i_wd_ready) begin
      if (w_exp_q.size() == 0) begin
        err_count++;
        $display("weight descriptor accepted when none was expected");
      end else begin
        exp_d = w_exp_q.pop_front();
        check_value("weights addr", exp_d.addr, o_wd.addr);
        check_value("weights len", exp_d.len, o_wd.len);
        check_value("weights user", exp_d.user, o_wd.user);
      end
    end
    if (rstn && o_xd_valid && i_xd_ready) begin
      x_acc++;
      if (x_exp_q.size() == 0) begin
        err_count++;
        $display("pixel descriptor accepted when none was expected");
      end else begin
        exp_d = x_exp_q.pop_front();
        check_value("pixels addr", exp_d.addr, o_xd.addr);
        check_value("pixels len", exp_d.len, o_xd.len);
        check_value("pixels user", exp_d.user, o_xd.user);
      end
    end
    if (rstn && o_od_valid && i_od_ready) begin
      od_acc++;
      if (od_exp_q.size() == 0) begin
        err_count++;
        $display("output descriptor accepted when no bank claim was expected");
      end else begin
        exp_o = od_exp_q.pop_front();
        check_value("output tag", exp_o.tag, o_od_tag);
        check_value("output addr", exp_o.addr, o_od_addr);
        check_value("output len", exp_o.len, o_od_len);
      end
    end
  end

  initial begin
    wait (limit_cycles != 0);
    repeat (limit_cycles) @(posedge clk);
    $display("timeout after %0d cycles, DUT stopped making progress", limit_cycles);
    $display("test failed");
    $finish;
  end

  initial begin
    logic [31:0] rd;
    logic [31:0] exp_val;
    int          seed_val;
    int          cum;
    rstn       = 1'b0;
    i_wr_en    = 1'b0;
    i_wr_addr  = '0;
    i_wr_data  = '0;
    i_rd_en    = 1'b0;
    i_rd_addr  = '0;
    i_o_valid  = 1'b0;
    i_o_ready  = 1'b0;
    i_o_last   = 1'b0;
    i_o_bpt    = 32'h0000_0400;
    i_os_valid = 1'b0;
    i_os_tag   = '0;
    i_os_error = '0;
    i_od_ready = 1'b0;
    seed_val   = $urandom(32'hc657_4ca8);  // seed once for the whole run

    for (int b = 0; b < N_BUNDLES; b++) begin
      bundles[b].header   = {$urandom, $urandom};
      bundles[b].max_t    = 16'(1 + $urandom % 3);
      bundles[b].max_p    = 16'(1 + $urandom % 3);
      bundles[b].w_bpt    = 1 + $urandom % 4096;
      bundles[b].w_bpt_p0 = 1 + $urandom % 4096;
      bundles[b].x_bpt    = 1 + $urandom % 4096;
      bundles[b].x_bpt_p0 = 1 + $urandom % 4096;
      bundles[b].x_base   = $urandom;
    end
    weights_base = $urandom;
    ocm_base[0]  = $urandom;
    ocm_base[1]  = $urandom;
    build_expected();
    limit_cycles = 64 * (w_exp_q.size() + x_exp_q.size() + 3) + 2000;

    repeat (16) @(negedge clk);
    rstn = 1'b1;

    // reset values with both generators idle so w_done and x_done read 1
    for (int a = 0; a < 13; a++) begin
      reg_read(a, rd);
      exp_val = (a == 1 || a == 2 || a == 8 || a == 10 || a == 11) ? 32'd1 : 32'd0;
      check_value($sformatf("reset value reg %0d", a), exp_val, rd);
    end
    reg_write(dma_pkg::R_OCM_BASE0, ocm_base[0]);
    reg_write(dma_pkg::R_OCM_BASE1, ocm_base[1]);
    reg_write(dma_pkg::R_WEIGHTS_BASE, weights_base);
    reg_write(dma_pkg::R_N_BUNDLES, N_BUNDLES);
    reg_read(dma_pkg::R_OCM_BASE0, rd);
    check_value("readback ocm base 0", ocm_base[0], rd);
    reg_read(dma_pkg::R_OCM_BASE1, rd);
    check_value("readback ocm base 1", ocm_base[1], rd);
    reg_read(dma_pkg::R_WEIGHTS_BASE, rd);
    check_value("readback weights base", weights_base, rd);
    reg_read(dma_pkg::R_N_BUNDLES, rd);
    check_value("readback n bundles", N_BUNDLES, rd);

    // bundle table rows with word 0 in the lowest bits
    for (int b = 0; b < N_BUNDLES; b++)
      for (int w = 0; w < 8; w++)
        reg_write(dma_pkg::REG_SPAN + b * 8 + w, bundles[b][w*32 +: 32]);

    reg_write(dma_pkg::R_BUNDLE_DONE, 32'd0);  // hold the pixels generator
    reg_write(dma_pkg::R_START, 32'd1);
    reg_read(dma_pkg::R_START, rd);
    check_value("start self clear", 32'd0, rd);

    while (w_exp_q.size() != 0)
      @(negedge clk);
    poll_reg("weights done", dma_pkg::R_W_DONE, 32'd1);

    cum = 0;
    for (int b = 0; b < N_BUNDLES; b++) begin
      repeat (10) @(negedge clk);
      check_value($sformatf("pixels held before go %0d", b), cum, x_acc);
      reg_write(dma_pkg::R_BUNDLE_DONE, 32'd1);
      cum += x_cnt[b];
      while (x_acc < cum)
        @(negedge clk);
    end
    poll_reg("pixels done", dma_pkg::R_X_DONE, 32'd1);

    // ping-pong claims on bank 0 then bank 1
    @(negedge clk);
    i_od_ready = 1'b1;
    od_exp_q.push_back({8'd0, ocm_base[0], i_o_bpt});
    engine_packet(3);
    od_exp_q.push_back({8'd1, ocm_base[1], i_o_bpt});
    engine_packet(3);
    engine_packet(3);  // bank 0 still unread so no claim
    repeat (4) @(negedge clk);
    check_value("third claim held", 2, od_acc);
    reg_write(dma_pkg::R_DONE_READ0, 32'd1);
    od_exp_q.push_back({8'd0, ocm_base[0], i_o_bpt});
    engine_packet(3);
    while (od_exp_q.size() != 0)
      @(negedge clk);

    send_status(8'd1, 4'd3);
    reg_read(dma_pkg::R_DONE_WRITE1, rd);
    check_value("bad status done write 1", 32'd0, rd);
    reg_read(dma_pkg::R_O_DONE, rd);
    check_value("o done after bad status", 32'd0, rd);
    send_status(8'd0, 4'd0);
    reg_read(dma_pkg::R_DONE_WRITE0, rd);
    check_value("good status done write 0", 32'd1, rd);
    reg_read(dma_pkg::R_O_DONE, rd);
    check_value("o done after good status", 32'd1, rd);

    $display("checks %0d errors %0d", check_count, err_count);
    if (err_count == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire
